// File: filelist.f
logic/geom_pkg.sv
logic/ctrl_pkg.sv
logic/frame_tick_gen.sv
logic/shot_fsm.sv
logic/missile_movement.sv
logic/missile_hit_detect.sv
logic/missile_subsystem.sv
verif/tb_missile_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the missile testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_missile_subsystem -f filelist.f

sim_out=$(./obj_dir/Vtb_missile_subsystem)
echo "$sim_out"

# Pass only if the testbench printed its pass line
if echo "$sim_out" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_missile_subsystem.sv
`timescale 1ns/1ps

module tb_missile_subsystem;

    import geom_pkg::*;

    localparam int FRAME_CYCLES = 40;
    localparam int CLK_PERIOD   = 4;
    localparam int X_SPEED      = 0;
    localparam int Y_SPEED      = -256;
    localparam int X_OFFSET     = 15;
    localparam int Y_OFFSET     = 0;
    // All tests together fit well inside this many frames
    localparam int MAX_FRAMES   = 60;

    logic         clk;
    logic         resetN;
    logic         fire_button;
    missile_pos_t ship_pos;
    missile_pos_t target_pos;
    missile_pos_t missile_pos;
    logic         missile_active;
    logic         activation_pulse;
    logic         collision;
    logic [3:0]   hit_edge_code;

    int errors;
    int checks;
    int seed;
    // Clock edges since reset was released, the DUT frame strobe is high after every 40th
    int cyc = 0;
    // Expected missile position in 1/64 pixel units
    int x_fp;
    int y_fp;

    missile_subsystem #(
        .FRAME_CYCLES (FRAME_CYCLES),
        .X_SPEED      (X_SPEED),
        .Y_SPEED      (Y_SPEED),
        .X_OFFSET     (X_OFFSET),
        .Y_OFFSET     (Y_OFFSET)
    ) missile_subsystem_i (
        .clk              (clk),
        .resetN           (resetN),
        .fire_button      (fire_button),
        .ship_pos         (ship_pos),
        .target_pos       (target_pos),
        .missile_pos      (missile_pos),
        .missile_active   (missile_active),
        .activation_pulse (activation_pulse),
        .collision        (collision),
        .hit_edge_code    (hit_edge_code)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    // Inputs are driven and outputs sampled 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR: %s is 0x%0h, expected 0x%0h at cycle %0d",
                     name, actual, expected, cyc);
        end
    endtask

    // The button is sampled at the next edge and the shot request is stored one edge later
    // The launch then takes the first frame strobe that sees the stored request
    function automatic int next_launch_cycle(input int press_cyc);
        return ((press_cyc + 2 + FRAME_CYCLES - 1) / FRAME_CYCLES) * FRAME_CYCLES + 1;
    endfunction

    // Gives -1 for no hit, 0 for a border exit, else the edge flags top, bottom, left, right
    function automatic int hit_code(input int mx, input int my, input missile_pos_t tgt);
        int tx;
        int ty;
        int code;
        tx = int'(tgt.x);
        ty = int'(tgt.y);
        code = -1;
        if (mx < tx + TARGET_W && tx < mx + MISSILE_W &&
            my < ty + TARGET_H && ty < my + MISSILE_H) begin
            code = (my < ty) ? 8 : 0;
            code += (my + MISSILE_H > ty + TARGET_H) ? 4 : 0;
            code += (mx < tx) ? 2 : 0;
            code += (mx + MISSILE_W > tx + TARGET_W) ? 1 : 0;
        end else if (my + MISSILE_H <= 0) begin
            code = 0;
        end
        return code;
    endfunction

    task automatic watch_idle(input int n_cycles);
        repeat (n_cycles) begin
            step_cycle();
            check_value("missile_active", 32'(missile_active), 0);
            check_value("activation_pulse", 32'(activation_pulse), 0);
            check_value("collision", 32'(collision), 0);
        end
    endtask

    // Releases the button, presses it once and expects the launch at the predicted strobe
    task automatic launch_missile(input missile_pos_t ship);
        int launch_cyc;
        ship_pos = ship;
        fire_button = 1'b0;
        repeat (3) step_cycle();
        fire_button = 1'b1;
        launch_cyc = next_launch_cycle(cyc);
        while (activation_pulse !== 1'b1 && cyc < launch_cyc + FRAME_CYCLES) begin
            step_cycle();
        end
        x_fp = (int'(ship.x) + X_OFFSET) * FIXED_SCALE;
        y_fp = (int'(ship.y) + Y_OFFSET) * FIXED_SCALE;
        if (activation_pulse !== 1'b1) begin
            errors++;
            $display("The missile did not launch after the fire button was pressed");
        end else begin
            check_value("launch cycle", cyc, launch_cyc);
            check_value("missile_active", 32'(missile_active), 1);
            check_value("missile_pos.x", 32'(missile_pos.x), x_fp / FIXED_SCALE);
            check_value("missile_pos.y", 32'(missile_pos.y), y_fp / FIXED_SCALE);
        end
    endtask

    // Follows the missile cycle by cycle until the detector takes it away
    task automatic fly_until_gone(input missile_pos_t tgt, input bit repress);
        int exp_code;
        int n;
        bit gone;
        exp_code = hit_code(x_fp / FIXED_SCALE, y_fp / FIXED_SCALE, tgt);
        gone = 1'b0;
        n = 0;
        while (!gone && n < MAX_FRAMES * FRAME_CYCLES) begin
            step_cycle();
            n++;
            // A release and a new press in the middle of the flight
            if (repress && n == 10) begin
                fire_button = 1'b0;
            end
            if (repress && n == 14) begin
                fire_button = 1'b1;
            end
            check_value("activation_pulse", 32'(activation_pulse), 0);
            check_value("collision", 32'(collision), 32'(exp_code >= 0));
            if (exp_code >= 0) begin
                check_value("hit_edge_code", 32'(hit_edge_code), exp_code);
                step_cycle();
                check_value("missile_active", 32'(missile_active), 0);
                check_value("collision", 32'(collision), 0);
                gone = 1'b1;
            end else begin
                check_value("missile_active", 32'(missile_active), 1);
                if (cyc % FRAME_CYCLES == 1) begin
                    x_fp += X_SPEED;
                    y_fp += Y_SPEED;
                    exp_code = hit_code(x_fp / FIXED_SCALE, y_fp / FIXED_SCALE, tgt);
                end
                check_value("missile_pos.x", 32'(missile_pos.x), x_fp / FIXED_SCALE);
                check_value("missile_pos.y", 32'(missile_pos.y), y_fp / FIXED_SCALE);
            end
        end
        if (!gone) begin
            errors++;
            $display("The missile never left the screen and never hit anything");
        end
    endtask

    task automatic check_idle_after_reset();
        check_value("missile_active", 32'(missile_active), 0);
        check_value("activation_pulse", 32'(activation_pulse), 0);
        check_value("collision", 32'(collision), 0);
        watch_idle(2 * FRAME_CYCLES);
    endtask

    // Two flights from random ship columns up to the top border, target out of the way
    task automatic fly_to_border_random();
        missile_pos_t ship;
        int r;
        target_pos = '{x: coord_t'(900), y: coord_t'(200)};
        repeat (2) begin
            r = $random(seed);
            ship.x = coord_t'(16 + ((r % 400) + 400) % 400);
            ship.y = coord_t'(24);
            launch_missile(ship);
            fly_until_gone(target_pos, 1'b0);
        end
    endtask

    // Holding the button and a second press in flight must not fire again
    task automatic hold_and_repress();
        launch_missile('{x: coord_t'(100), y: coord_t'(24)});
        fly_until_gone(target_pos, 1'b1);
        watch_idle(2 * FRAME_CYCLES);
    endtask

    // Missile comes from below, so it sticks out past the bottom edge of the target
    task automatic hit_target_from_below();
        target_pos = '{x: coord_t'(210), y: coord_t'(10)};
        launch_missile('{x: coord_t'(200), y: coord_t'(48)});
        fly_until_gone(target_pos, 1'b0);
        check_value("hit_edge_code bottom", 32'(hit_edge_code[2]), 1);
        watch_idle(4);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        seed = 76;
        x_fp = 0;
        y_fp = 0;
        resetN = 1'b0;
        fire_button = 1'b0;
        ship_pos = '0;
        target_pos = '0;
        repeat (3) @(posedge clk);
        #1;
        resetN = 1'b1;
        check_idle_after_reset();
        fly_to_border_random();
        hold_and_repress();
        hit_target_from_below();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Stops a run that hangs, e.g. waiting for a missile that never goes away
    initial begin
        #(MAX_FRAMES * FRAME_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d frame periods", MAX_FRAMES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: logic/missile_subsystem.sv
`timescale 1ns/1ps

module missile_subsystem #(
    parameter int FRAME_CYCLES = 1666667,
    parameter int X_SPEED      = 0,
    parameter int Y_SPEED      = -256,
    parameter int X_OFFSET     = 15,
    parameter int Y_OFFSET     = 0
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   fire_button,
    input  geom_pkg::missile_pos_t ship_pos,
    input  geom_pkg::missile_pos_t target_pos,
    output geom_pkg::missile_pos_t missile_pos,
    output logic                   missile_active,
    output logic                   activation_pulse,
    output logic                   collision,
    output logic [3:0]             hit_edge_code
);

    import ctrl_pkg::*;

    logic      start_of_frame;
    logic      shooting_pulse;
    hit_edge_u hit_edge;

    // Frame strobe, in the real game it comes from the video timing
    frame_tick_gen #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) frame_tick_gen_i (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame)
    );

    // Turns button presses into single shot requests
    shot_fsm shot_fsm_i (
        .clk              (clk),
        .resetN           (resetN),
        .fire_button      (fire_button),
        .activation_pulse (activation_pulse),
        .missile_active   (missile_active),
        .shooting_pulse   (shooting_pulse)
    );

    missile_movement #(
        .X_SPEED  (X_SPEED),
        .Y_SPEED  (Y_SPEED),
        .X_OFFSET (X_OFFSET),
        .Y_OFFSET (Y_OFFSET)
    ) missile_movement_i (
        .clk              (clk),
        .resetN           (resetN),
        .start_of_frame   (start_of_frame),
        .shooting_pulse   (shooting_pulse),
        .collision        (collision),
        .ship_pos         (ship_pos),
        .missile_pos      (missile_pos),
        .missile_active   (missile_active),
        .activation_pulse (activation_pulse)
    );

    // Closes the loop back to the mover through collision
    missile_hit_detect missile_hit_detect_i (
        .clk            (clk),
        .resetN         (resetN),
        .missile_active (missile_active),
        .missile_pos    (missile_pos),
        .target_pos     (target_pos),
        .collision      (collision),
        .hit_edge       (hit_edge)
    );

    // Outside the block only the raw nibble is visible
    assign hit_edge_code = hit_edge.code;

endmodule

// File: logic/missile_hit_detect.sv
`timescale 1ns/1ps

module missile_hit_detect (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   missile_active,
    input  geom_pkg::missile_pos_t missile_pos,
    input  geom_pkg::missile_pos_t target_pos,
    output logic                   collision,
    output ctrl_pkg::hit_edge_u    hit_edge
);

    import geom_pkg::*;
    import ctrl_pkg::*;

    // Two spare bits so that corner plus box size never wraps
    localparam int EXT_W = PIXEL_WIDTH + 2;

    typedef logic signed [EXT_W-1:0] ext_t;

    // Box edges, right and bottom are one past the last pixel
    ext_t m_left;
    ext_t m_right;
    ext_t m_top;
    ext_t m_bottom;
    ext_t t_left;
    ext_t t_right;
    ext_t t_top;
    ext_t t_bottom;

    logic         overlap;
    logic         border_exit;
    logic         new_pos;
    logic         active_q;
    missile_pos_t pos_q;
    hit_edge_u    edge_next;

    assign m_left   = ext_t'(missile_pos.x);
    assign m_right  = m_left + ext_t'(MISSILE_W);
    assign m_top    = ext_t'(missile_pos.y);
    assign m_bottom = m_top + ext_t'(MISSILE_H);
    assign t_left   = ext_t'(target_pos.x);
    assign t_right  = t_left + ext_t'(TARGET_W);
    assign t_top    = ext_t'(target_pos.y);
    assign t_bottom = t_top + ext_t'(TARGET_H);

    // Half-open intervals overlap when each one starts before the other ends
    assign overlap = (m_left < t_right) && (t_left < m_right) &&
                     (m_top < t_bottom) && (t_top < m_bottom);

    // Whole missile box is above the first visible row
    assign border_exit = (m_bottom <= ext_t'(SCREEN_TOP));

    // Checked once on launch and once after each frame step, never again for the same spot
    assign new_pos = missile_active && (!active_q || (missile_pos != pos_q));

    // Flags name the target edges that the missile box sticks out past
    always_comb begin
        edge_next              = '0;
        edge_next.edges.top    = overlap && (m_top < t_top);
        edge_next.edges.bottom = overlap && (m_bottom > t_bottom);
        edge_next.edges.left   = overlap && (m_left < t_left);
        edge_next.edges.right  = overlap && (m_right > t_right);
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            active_q  <= 1'b0;
            collision <= 1'b0;
            hit_edge  <= '0;
        end else begin
            active_q  <= missile_active;
            collision <= new_pos && (overlap || border_exit);
            // Border exits leave a zero code
            if (new_pos) begin
                hit_edge <= edge_next;
            end
        end
    end

    // Last position that was checked
    always_ff @(posedge clk) begin
        pos_q <= missile_pos;
    end

    // A hit is only reported for a missile that is still on screen
    a_collision_needs_missile : assert property (
        @(posedge clk) disable iff (!resetN)
        $rose(collision) |-> missile_active
    );

endmodule

// File: logic/missile_movement.sv
`timescale 1ns/1ps

module missile_movement #(
    parameter int X_SPEED  = 0,
    parameter int Y_SPEED  = -256,
    parameter int X_OFFSET = 15,
    parameter int Y_OFFSET = 0
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  start_of_frame,
    input  logic                  shooting_pulse,
    input  logic                  collision,
    input  geom_pkg::missile_pos_t ship_pos,
    output geom_pkg::missile_pos_t missile_pos,
    output logic                  missile_active,
    output logic                  activation_pulse
);

    import geom_pkg::*;

    // Integer pixel part plus six fraction bits
    localparam int FP_W = PIXEL_WIDTH + FIXED_SHIFT;

    typedef logic signed [FP_W-1:0] fixed_t;

    // Position in 1/64 pixel units
    fixed_t x_fp;
    fixed_t y_fp;

    // Launch point scaled up to the fixed-point grid
    fixed_t launch_x;
    fixed_t launch_y;

    // A shot that still waits for the next frame boundary
    logic shot_pending;

    // missile_active one clock earlier, for the rising edge
    logic active_d;

    // Ship corner plus the offset that puts the missile at the nose
    assign launch_x = fixed_t'((int'(ship_pos.x) + X_OFFSET) * FIXED_SCALE);
    assign launch_y = fixed_t'((int'(ship_pos.y) + Y_OFFSET) * FIXED_SCALE);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_fp           <= '0;
            y_fp           <= '0;
            shot_pending   <= 1'b0;
            missile_active <= 1'b0;
            active_d       <= 1'b0;
        end else begin
            active_d <= missile_active;

            if (start_of_frame && shot_pending) begin
                // Launch, the missile appears at the nose of the ship
                x_fp           <= launch_x;
                y_fp           <= launch_y;
                missile_active <= 1'b1;
            end else if (collision) begin
                // Hit or off screen, so the missile is taken away
                x_fp           <= '0;
                y_fp           <= '0;
                missile_active <= 1'b0;
            end else if (start_of_frame && missile_active) begin
                // One step per frame at a constant speed
                x_fp <= x_fp + fixed_t'(X_SPEED);
                y_fp <= y_fp + fixed_t'(Y_SPEED);
            end

            // A shot arriving together with a strobe stays pending for the following frame
            if (shooting_pulse) begin
                shot_pending <= 1'b1;
            end else if (start_of_frame) begin
                shot_pending <= 1'b0;
            end
        end
    end

    // Signed division truncates toward zero, so a slightly negative y still reads as row 0
    assign missile_pos = '{
        x: coord_t'(x_fp / FIXED_SCALE),
        y: coord_t'(y_fp / FIXED_SCALE)
    };

    // First clock of a new flight
    assign activation_pulse = missile_active & ~active_d;

    // A launch only ever happens on a frame strobe
    a_launch_on_frame : assert property (
        @(posedge clk) disable iff (!resetN)
        activation_pulse |-> missile_active && $past(start_of_frame)
    );

endmodule

// File: logic/shot_fsm.sv
`timescale 1ns/1ps

module shot_fsm (
    input  logic clk,
    input  logic resetN,
    input  logic fire_button,
    input  logic activation_pulse,
    input  logic missile_active,
    output logic shooting_pulse
);

    import ctrl_pkg::*;

    shot_state_t state;
    shot_state_t next_state;

    // Button sample and its copy from one clock earlier
    logic fire_q;
    logic fire_prev;
    logic fire_rise;

    // The button is a plain level from outside
    // It gets registered once, and the second stage finds the press edge
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            fire_q    <= 1'b0;
            fire_prev <= 1'b0;
            state     <= READY;
        end else begin
            fire_q    <= fire_button;
            fire_prev <= fire_q;
            state     <= next_state;
        end
    end

    // High for one clock right after a new press has been sampled
    assign fire_rise = fire_q & ~fire_prev;

    // A shot is granted only from READY and only with no missile on screen
    // The FSM leaves READY on the next clock, so the pulse never lasts longer than one cycle
    assign shooting_pulse = (state == READY) & fire_rise & ~missile_active;

    always_comb begin
        next_state = state;
        case (state)
            READY: begin
                if (shooting_pulse) begin
                    next_state = LAUNCH_WAIT;
                end
            end
            LAUNCH_WAIT: begin
                // The mover launches at the next frame strobe
                // Presses seen until then are dropped
                if (activation_pulse) begin
                    next_state = IN_FLIGHT;
                end
            end
            IN_FLIGHT: begin
                // Missile is gone, either off the top or into the target
                if (!missile_active) begin
                    next_state = RELEASE_WAIT;
                end
            end
            RELEASE_WAIT: begin
                // Holding the button does not auto-fire, so we wait for it to drop
                if (!fire_q) begin
                    next_state = READY;
                end
            end
            default: begin
                next_state = READY;
            end
        endcase
    end

    // Shots only come from READY, and READY is only reached once the last missile is gone
    // A shot can therefore never stack a second missile on one that is still flying
    a_ready_without_missile : assert property (
        @(posedge clk) disable iff (!resetN)
        (state == READY) |-> !missile_active
    );

endmodule

// File: logic/frame_tick_gen.sv
`timescale 1ns/1ps

module frame_tick_gen #(
    parameter int FRAME_CYCLES = 1666667
) (
    input  logic clk,
    input  logic resetN,
    output logic start_of_frame
);

    // Enough bits to hold FRAME_CYCLES-1
    localparam int CNT_W = $clog2(FRAME_CYCLES);

    logic [CNT_W-1:0] frame_cnt;

    // The counter sits at zero out of reset and wraps to the top on the first clock,
    // so it passes 1 for the first time FRAME_CYCLES-1 clocks later
    // The strobe is registered from that compare and shows up one clock after it
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            frame_cnt      <= '0;
            start_of_frame <= 1'b0;
        end else begin
            // Fires exactly once per trip around the counter
            start_of_frame <= (frame_cnt == CNT_W'(1));
            if (frame_cnt == '0) begin
                frame_cnt <= CNT_W'(FRAME_CYCLES - 1);
            end else begin
                frame_cnt <= frame_cnt - 1'b1;
            end
        end
    end

    // The mover steps once per strobe, so a strobe that lasts two clocks would double the speed
    a_sof_single_cycle : assert property (
        @(posedge clk) disable iff (!resetN)
        start_of_frame |=> !start_of_frame
    );

endmodule

// File: logic/ctrl_pkg.sv
package ctrl_pkg;

    // States of the fire control FSM
    // READY waits for a press, LAUNCH_WAIT waits for the mover to launch,
    // IN_FLIGHT waits for the missile to go away, RELEASE_WAIT waits for the button to drop
    typedef enum logic [1:0] {
        READY        = 2'd0,
        LAUNCH_WAIT  = 2'd1,
        IN_FLIGHT    = 2'd2,
        RELEASE_WAIT = 2'd3
    } shot_state_t;

    // One flag per edge of the target box that the missile box sticks out of
    // Top is the most significant bit of the code
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } hit_edges_t;

    // The detector writes the flags one by one
    // Everything downstream only sees the raw nibble
    typedef union packed {
        logic [3:0] code;
        hit_edges_t edges;
    } hit_edge_u;

endpackage

// File: logic/geom_pkg.sv
package geom_pkg;

    // Signed screen coordinate width in pixels
    // Negative values are legal while an object is partly off the top or left edge
    localparam int PIXEL_WIDTH = 11;

    // The mover works in 1/64 pixel steps, so positions carry six fraction bits
    localparam int FIXED_SHIFT = 6;
    localparam int FIXED_SCALE = 1 << FIXED_SHIFT;

    // Row of the top screen border
    // A missile whose bottom edge is at or above it has left the screen
    localparam int SCREEN_TOP = 0;

    // One screen coordinate
    typedef logic signed [PIXEL_WIDTH-1:0] coord_t;

    // Top-left corner of an object on the screen
    // Used for the ship, the target and the missile alike
    typedef struct packed {
        coord_t x;
        coord_t y;
    } missile_pos_t;

    // Missile box size in pixels
    localparam int MISSILE_W = 4;
    localparam int MISSILE_H = 8;

    // Target box size in pixels
    localparam int TARGET_W = 32;
    localparam int TARGET_H = 16;

endpackage
